//--- slave_translator.f
hdl/translator_bus_pkg.sv
hdl/slave_timing_pkg.sv
hdl/address_translator.sv
hdl/wait_state_sequencer.sv
hdl/read_latency_pipe.sv
hdl/transfer_marker.sv
hdl/slave_translator.sv
testbench/tb_clock_gen.sv
testbench/slave_translator_properties.sv
testbench/tb_slave_translator.sv

//--- Makefile
# Verilator build and run for the slave translator testbench

VERILATOR ?= verilator
TOP       ?= tb_slave_translator
FILELIST  ?= slave_translator.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= >>> PASS

SOURCES := $(wildcard hdl/*.sv testbench/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out="$$($(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_slave_translator.sv
// Fixed table and seed; idle gaps between entries keep the address-driven slave model valid
`timescale 1ns/1ns

module tb_slave_translator;

   import translator_bus_pkg::*;
   import slave_timing_pkg::*;

   localparam int DRIVE_DELAY = 5;
   localparam int WAIT_LIMIT  = 16;
   localparam int NUM_ENTRIES = 7;

   typedef enum logic [1:0] {KIND_READ, KIND_WRITE, KIND_BURST} kind_t;

   typedef struct packed {
      kind_t                    kind;
      logic [UAV_ADDRESS_W-1:0] address;
      logic [DATA_W-1:0]        data;
      logic [BYTEENABLE_W-1:0]  byteenable;
      int                       beats;
   } entry_t;

   logic                        clk;
   logic                        reset;
   uav_address_t                uav_address;
   logic [DATA_W-1:0]           uav_writedata;
   logic                        uav_write;
   logic                        uav_read;
   logic [UAV_BURSTCOUNT_W-1:0] uav_burstcount;
   logic [BYTEENABLE_W-1:0]     uav_byteenable;
   logic                        uav_waitrequest;
   logic [DATA_W-1:0]           uav_readdata;
   logic                        uav_readdatavalid;
   logic [AV_ADDRESS_W-1:0]     av_address;
   logic [DATA_W-1:0]           av_writedata;
   logic                        av_write;
   logic                        av_read;
   logic [AV_BURSTCOUNT_W-1:0]  av_burstcount;
   logic [BYTEENABLE_W-1:0]     av_byteenable;
   logic [BYTEENABLE_W-1:0]     av_writebyteenable;
   logic                        av_begintransfer;
   logic                        av_beginbursttransfer;
   logic                        av_chipselect;
   logic [DATA_W-1:0]           av_readdata;

   entry_t table_entries [NUM_ENTRIES];
   integer seed = 28806;
   string  test_name;
   int     test_errors;
   int     error_count;
   int     check_count;
   int     test_count;
   int     failed_tests;

   tb_clock_gen clock_source (
      .clk   (clk),
      .reset (reset)
   );

   slave_translator UUT (.*);

   bind slave_translator slave_translator_properties u_properties (
      .clk                   (clk),
      .reset                 (reset),
      .uav_write             (uav_write),
      .uav_waitrequest       (uav_waitrequest),
      .uav_readdatavalid     (uav_readdatavalid),
      .read_accept           (read_accept),
      .av_write              (av_write),
      .av_begintransfer      (av_begintransfer),
      .av_beginbursttransfer (av_beginbursttransfer)
   );

   // ---------------------------------------------------------------------
   // Slave model and address prediction
   // ---------------------------------------------------------------------
   function automatic logic [DATA_W-1:0] slave_word(input logic [AV_ADDRESS_W-1:0] word);
      return {word ^ 16'h5AC3, ~word};
   endfunction

   assign av_readdata = slave_word(av_address);

   // Word address from the raw byte view
   function automatic logic [AV_ADDRESS_W-1:0] word_of(input logic [UAV_ADDRESS_W-1:0] raw);
      return AV_ADDRESS_W'(raw >> BYTE_OFFSET_W);
   endfunction

   // ---------------------------------------------------------------------
   // Reporting
   // ---------------------------------------------------------------------
   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
      check_count++;
      assert (got === expected) else begin
         $display("[FAIL] %s: %s = 0x%0h, expected 0x%0h", test_name, name, got, expected);
         test_errors++;
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic expected);
      compare_word(name, {31'b0, got}, {31'b0, expected});
   endtask

   task automatic report_timeout(input string what);
      $display("[TIMEOUT] %s: %s within %0d cycles", test_name, what, WAIT_LIMIT);
      test_errors++;
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      test_count++;
      error_count += test_errors;
      if (test_errors == 0) begin
         $display("%s: ok", test_name);
      end else begin
         failed_tests++;
         $display("%s: %0d errors", test_name, test_errors);
      end
   endtask

   // ---------------------------------------------------------------------
   // Stimulus helpers
   // ---------------------------------------------------------------------
   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic drive_idle();
      uav_read  = 1'b0;
      uav_write = 1'b0;
   endtask

   // Control outputs between requests
   task automatic idle_outputs_low();
      compare_bit("av_chipselect", av_chipselect, 1'b0);
      compare_bit("av_read", av_read, 1'b0);
      compare_bit("av_write", av_write, 1'b0);
      compare_bit("av_begintransfer", av_begintransfer, 1'b0);
      compare_bit("av_beginbursttransfer", av_beginbursttransfer, 1'b0);
   endtask

   task automatic set_entry(input int index, input kind_t kind,
                            input logic [UAV_ADDRESS_W-1:0] address, input int beats);
      table_entries[index].kind       = kind;
      table_entries[index].address    = address;
      table_entries[index].data       = $random(seed);
      table_entries[index].byteenable = BYTEENABLE_W'($random(seed));
      table_entries[index].beats      = beats;
   endtask

   task automatic load_table();
      set_entry(0, KIND_READ,  32'h0000_0010, 1);
      set_entry(1, KIND_WRITE, 32'h0000_0124, 1);
      set_entry(2, KIND_BURST, 32'h0000_0200, 3);
      set_entry(3, KIND_READ,  32'h0000_ABC8, 1);
      set_entry(4, KIND_WRITE, 32'h0001_0044, 1);
      set_entry(5, KIND_BURST, 32'h0000_3000, 3);
      set_entry(6, KIND_READ,  32'h0000_0FFC, 1);
   endtask

   // ---------------------------------------------------------------------
   // Tests
   // ---------------------------------------------------------------------
   task automatic reset_state_test();
      int n;
      start_test("reset state");
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (reset && n < WAIT_LIMIT);
      if (reset) begin
         report_timeout("reset never released");
      end else begin
         compare_bit("uav_waitrequest", uav_waitrequest, 1'b1);
         compare_bit("uav_readdatavalid", uav_readdatavalid, 1'b0);
         idle_outputs_low();
      end
      end_test();
   endtask

   // Holds one beat until waitrequest drops, checking every waiting cycle
   task automatic run_beat(input entry_t e, input int beat, output bit accepted);
      int                count;
      int                accept_index;
      bit                is_read;
      logic [DATA_W-1:0] beat_data;
      is_read      = (e.kind == KIND_READ);
      accept_index = is_read ? READ_WAIT_INDEXED : DATA_HOLD_INDEXED;
      beat_data    = e.data + DATA_W'(beat);
      uav_address.raw = e.address + UAV_ADDRESS_W'(beat * BYTES_PER_WORD);
      uav_writedata   = beat_data;
      uav_byteenable  = e.byteenable;
      uav_burstcount  = UAV_BURSTCOUNT_W'((e.beats - beat) * BYTES_PER_WORD);
      uav_read        = is_read;
      uav_write       = !is_read;
      count    = 0;
      accepted = 1'b0;
      while (!accepted && count <= WAIT_LIMIT) begin
         @(negedge clk);
         compare_bit("av_chipselect", av_chipselect, 1'b1);
         compare_bit("av_begintransfer", av_begintransfer, count == 0);
         compare_bit("av_beginbursttransfer", av_beginbursttransfer, count == 0 && beat == 0);
         compare_word("av_address", 32'(av_address), 32'(word_of(e.address)));
         compare_word("av_burstcount", 32'(av_burstcount), 32'(e.beats));
         compare_word("av_byteenable", 32'(av_byteenable), 32'(e.byteenable));
         compare_bit("uav_readdatavalid", uav_readdatavalid, 1'b0);
         if (is_read) begin
            compare_bit("av_read", av_read, count >= SETUP_WAIT_CYCLES);
            compare_bit("av_write", av_write, 1'b0);
            compare_word("av_writebyteenable", 32'(av_writebyteenable), 32'h0);
         end else begin
            compare_bit("av_read", av_read, 1'b0);
            compare_bit("av_write", av_write,
                        count >= SETUP_WAIT_CYCLES && count <= WRITE_WAIT_INDEXED);
            compare_word("av_writedata", av_writedata, beat_data);
            compare_word("av_writebyteenable", 32'(av_writebyteenable), 32'(e.byteenable));
         end
         if (!uav_waitrequest) begin
            accepted = 1'b1;
            compare_word("accept count", count, accept_index);
         end else begin
            count++;
            next_cycle();
         end
      end
      if (!accepted) begin
         report_timeout("waitrequest never dropped");
      end
   endtask

   task automatic apply_entry(input int index);
      entry_t e;
      bit     accepted;
      bit     valid_seen;
      int     beat;
      int     latency;
      e = table_entries[index];
      start_test($sformatf("entry %0d %s 0x%08h", index, e.kind.name(), e.address));
      accepted = 1'b1;
      for (beat = 0; beat < e.beats && accepted; beat++) begin
         next_cycle();
         run_beat(e, beat, accepted);
      end
      next_cycle();
      drive_idle();
      if (e.kind == KIND_READ && accepted) begin
         valid_seen = 1'b0;
         latency    = 0;
         while (!valid_seen && latency < WAIT_LIMIT) begin
            @(negedge clk);
            latency++;
            idle_outputs_low();
            if (uav_readdatavalid) begin
               valid_seen = 1'b1;
               compare_word("read latency", latency, READ_LATENCY);
               compare_word("uav_readdata", uav_readdata, slave_word(word_of(e.address)));
            end else begin
               next_cycle();
            end
         end
         if (!valid_seen) begin
            report_timeout("readdatavalid never rose");
         end
      end else begin
         @(negedge clk);
         idle_outputs_low();
         compare_bit("uav_readdatavalid", uav_readdatavalid, 1'b0);
      end
      end_test();
   endtask

   // ---------------------------------------------------------------------
   // Main sequence
   // ---------------------------------------------------------------------
   initial begin
      uav_address    = '0;
      uav_writedata  = '0;
      uav_write      = 1'b0;
      uav_read       = 1'b0;
      uav_burstcount = '0;
      uav_byteenable = '0;
      load_table();
      reset_state_test();
      for (int index = 0; index < NUM_ENTRIES; index++) begin
         apply_entry(index);
      end
      // Protocol assertion failures count as errors too
      error_count += UUT.u_properties.failures;
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- testbench/slave_translator_properties.sv
// Protocol relations only; needs the internal read_accept of the top level through bind
`timescale 1ns/1ns

module slave_translator_properties (
   input logic clk,
   input logic reset,
   input logic uav_write,
   input logic uav_waitrequest,
   input logic uav_readdatavalid,
   input logic read_accept,
   input logic av_write,
   input logic av_begintransfer,
   input logic av_beginbursttransfer
);

   import slave_timing_pkg::*;

   int failures = 0;

   // ---------------------------------------------------------------------
   // Reset and read return
   // ---------------------------------------------------------------------
   waitrequest_after_reset : assert property (@(posedge clk) $fell(reset) |-> uav_waitrequest)
      else begin
         $error("waitrequest low in the first cycle after reset");
         failures++;
      end

   readdatavalid_after_accept : assert property (@(posedge clk) disable iff (reset)
      read_accept |-> ##READ_LATENCY uav_readdatavalid)
      else begin
         $error("readdatavalid missing after an accepted read");
         failures++;
      end

   readdatavalid_has_accept : assert property (@(posedge clk) disable iff (reset)
      uav_readdatavalid |-> $past(read_accept, READ_LATENCY))
      else begin
         $error("readdatavalid without an accepted read");
         failures++;
      end

   // ---------------------------------------------------------------------
   // Slave strobes and markers
   // ---------------------------------------------------------------------
   // Write strobe ends before the accepting data hold cycle
   write_needs_master_write : assert property (@(posedge clk) disable iff (reset)
      av_write |-> uav_write && uav_waitrequest)
      else begin
         $error("av_write high outside a waiting master write");
         failures++;
      end

   burst_begin_is_transfer_begin : assert property (@(posedge clk) disable iff (reset)
      av_beginbursttransfer |-> av_begintransfer && !$past(av_begintransfer))
      else begin
         $error("beginbursttransfer without a fresh begintransfer");
         failures++;
      end

endmodule

//--- testbench/tb_clock_gen.sv
// Free-running 40 ns clock; reset high from time 0 and released a few ns after the 2nd rising edge
`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk,
   output logic reset
);

   localparam int HALF_PERIOD  = 20;
   localparam int RESET_CYCLES = 2;
   localparam int DRIVE_DELAY  = 5;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Release follows the same drive offset as the other stimulus
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY reset = 1'b0;
   end

endmodule

//--- hdl/slave_translator.sv
// Fixed-timing slave only: no slave waitrequest, no readdatavalid, no responses, equal data widths
`timescale 1ns/1ns

module slave_translator (
   input  logic                                            clk,
   input  logic                                            reset,

   // ---------------------------------------------------------------------
   // Universal master side
   // ---------------------------------------------------------------------
   input  translator_bus_pkg::uav_address_t                uav_address,
   input  logic [translator_bus_pkg::DATA_W-1:0]           uav_writedata,
   input  logic                                            uav_write,
   input  logic                                            uav_read,
   input  logic [translator_bus_pkg::UAV_BURSTCOUNT_W-1:0] uav_burstcount,
   input  logic [translator_bus_pkg::BYTEENABLE_W-1:0]     uav_byteenable,
   output logic                                            uav_waitrequest,
   output logic [translator_bus_pkg::DATA_W-1:0]           uav_readdata,
   output logic                                            uav_readdatavalid,

   // ---------------------------------------------------------------------
   // Word-addressed slave side
   // ---------------------------------------------------------------------
   output logic [translator_bus_pkg::AV_ADDRESS_W-1:0]     av_address,
   output logic [translator_bus_pkg::DATA_W-1:0]           av_writedata,
   output logic                                            av_write,
   output logic                                            av_read,
   output logic [translator_bus_pkg::AV_BURSTCOUNT_W-1:0]  av_burstcount,
   output logic [translator_bus_pkg::BYTEENABLE_W-1:0]     av_byteenable,
   output logic [translator_bus_pkg::BYTEENABLE_W-1:0]     av_writebyteenable,
   output logic                                            av_begintransfer,
   output logic                                            av_beginbursttransfer,
   output logic                                            av_chipselect,
   input  logic [translator_bus_pkg::DATA_W-1:0]           av_readdata
);

   logic read_accept;
   logic reset_override;

   // Data paths pass straight through
   assign av_writedata  = uav_writedata;
   assign av_byteenable = uav_byteenable;
   assign uav_readdata  = av_readdata;

   // ---------------------------------------------------------------------
   // Address and burst count
   // ---------------------------------------------------------------------
   address_translator u_address_translator (
      .clk                   (clk),
      .reset                 (reset),
      .uav_address           (uav_address),
      .uav_burstcount        (uav_burstcount),
      .uav_byteenable        (uav_byteenable),
      .uav_write             (uav_write),
      .av_beginbursttransfer (av_beginbursttransfer),
      .av_address            (av_address),
      .av_burstcount         (av_burstcount),
      .av_writebyteenable    (av_writebyteenable)
   );

   // ---------------------------------------------------------------------
   // Wait states and strobes
   // ---------------------------------------------------------------------
   wait_state_sequencer u_wait_state_sequencer (
      .clk             (clk),
      .reset           (reset),
      .uav_read        (uav_read),
      .uav_write       (uav_write),
      .av_read         (av_read),
      .av_write        (av_write),
      .uav_waitrequest (uav_waitrequest),
      .read_accept     (read_accept),
      .reset_override  (reset_override)
   );

   // Readdatavalid from accepted reads
   read_latency_pipe u_read_latency_pipe (
      .clk               (clk),
      .reset             (reset),
      .read_accept       (read_accept),
      .uav_readdatavalid (uav_readdatavalid)
   );

   // ---------------------------------------------------------------------
   // Transfer markers and chipselect
   // ---------------------------------------------------------------------
   transfer_marker u_transfer_marker (
      .clk                   (clk),
      .reset                 (reset),
      .uav_read              (uav_read),
      .uav_write             (uav_write),
      .uav_burstcount        (uav_burstcount),
      .uav_waitrequest       (uav_waitrequest),
      .reset_override        (reset_override),
      .av_begintransfer      (av_begintransfer),
      .av_beginbursttransfer (av_beginbursttransfer),
      .av_chipselect         (av_chipselect)
   );

endmodule

//--- hdl/transfer_marker.sv
// Bursts are write only; a read always counts as a one-beat burst of its own
`timescale 1ns/1ns

module transfer_marker (
   input  logic                                            clk,
   input  logic                                            reset,
   input  logic                                            uav_read,
   input  logic                                            uav_write,
   input  logic [translator_bus_pkg::UAV_BURSTCOUNT_W-1:0] uav_burstcount,
   input  logic                                            uav_waitrequest,
   input  logic                                            reset_override,
   output logic                                            av_begintransfer,
   output logic                                            av_beginbursttransfer,
   output logic                                            av_chipselect
);

   import translator_bus_pkg::*;

   logic request;
   logic end_begintransfer;
   logic in_burst;
   logic last_beat;

   assign request   = uav_read | uav_write;
   assign last_beat = uav_burstcount == UAV_BURSTCOUNT_W'(BYTES_PER_WORD);

   // ---------------------------------------------------------------------
   // Begintransfer
   // ---------------------------------------------------------------------
   assign av_begintransfer = request & ~end_begintransfer;

   // Blocks the pulse for the rest of a waiting beat
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_begintransfer <= 1'b0;
      end else if (av_begintransfer && uav_waitrequest && !reset_override) begin
         end_begintransfer <= 1'b1;
      end else if (!uav_waitrequest) begin
         end_begintransfer <= 1'b0;
      end
   end

   // ---------------------------------------------------------------------
   // Beginbursttransfer
   // ---------------------------------------------------------------------
   // Set when a non-final write beat is accepted
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_burst <= 1'b0;
      end else if (uav_write && !uav_waitrequest) begin
         in_burst <= !last_beat;
      end
   end

   assign av_beginbursttransfer = uav_read ? av_begintransfer
                                           : (av_begintransfer & ~in_burst);

   // Select follows any held request
   assign av_chipselect = request;

endmodule

//--- hdl/read_latency_pipe.sv
// Fixed latency only; the slave must return data exactly READ_LATENCY cycles after acceptance
`timescale 1ns/1ns

module read_latency_pipe (
   input  logic clk,
   input  logic reset,
   input  logic read_accept,
   output logic uav_readdatavalid
);

   import slave_timing_pkg::*;

   // One stage per cycle of latency
   logic [READ_LATENCY-1:0] valid_shift;

   // ---------------------------------------------------------------------
   // Valid shift register
   // ---------------------------------------------------------------------
   // Back-to-back accepts travel as separate bits
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         valid_shift <= '0;
      end else begin
         valid_shift[0] <= read_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            valid_shift[i] <= valid_shift[i-1];
         end
      end
   end

   // Oldest stage is the data-valid strobe
   assign uav_readdatavalid = valid_shift[READ_LATENCY-1];

endmodule

//--- hdl/wait_state_sequencer.sv
// Slave has no waitrequest; acceptance is purely count based, read and write never held together
`timescale 1ns/1ns

module wait_state_sequencer (
   input  logic clk,
   input  logic reset,
   input  logic uav_read,
   input  logic uav_write,
   output logic av_read,
   output logic av_write,
   output logic uav_waitrequest,
   output logic read_accept,
   output logic reset_override
);

   import slave_timing_pkg::*;

   logic [WAIT_COUNT_W-1:0] wait_count;
   logic                    read_wait;
   logic                    write_wait;

   // ---------------------------------------------------------------------
   // Wait counter
   // ---------------------------------------------------------------------
   // Counts from the first held cycle, cleared after each acceptance
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_count     <= '0;
         reset_override <= 1'b1;
      end else begin
         reset_override <= 1'b0;
         if (!uav_waitrequest || reset_override) begin
            wait_count <= '0;
         end else if (uav_read || uav_write) begin
            wait_count <= wait_count + 1'b1;
         end else begin
            wait_count <= '0;
         end
      end
   end

   // ---------------------------------------------------------------------
   // Qualified slave strobes
   // ---------------------------------------------------------------------
   // Read stays up from end of setup until acceptance
   assign av_read = uav_read && (wait_count >= WAIT_COUNT_W'(SETUP_WAIT_CYCLES));

   // Write drops before the data hold cycles
   assign av_write = uav_write
                     && (wait_count >= WAIT_COUNT_W'(SETUP_WAIT_CYCLES))
                     && (wait_count <= WAIT_COUNT_W'(WRITE_WAIT_INDEXED));

   // ---------------------------------------------------------------------
   // Generated waitrequest
   // ---------------------------------------------------------------------
   assign read_wait  = wait_count != WAIT_COUNT_W'(READ_WAIT_INDEXED);
   assign write_wait = wait_count != WAIT_COUNT_W'(DATA_HOLD_INDEXED);

   always_comb begin
      if (uav_write) begin
         uav_waitrequest = write_wait | reset_override;
      end else begin
         uav_waitrequest = read_wait | reset_override;
      end
   end

   // Feeds the latency pipe
   assign read_accept = uav_read && !uav_waitrequest;

endmodule

//--- hdl/address_translator.sv
// Word address takes the low AV_ADDRESS_W bits of the word index; higher bits are dropped
`timescale 1ns/1ns

module address_translator (
   input  logic                                              clk,
   input  logic                                              reset,
   input  translator_bus_pkg::uav_address_t                  uav_address,
   input  logic [translator_bus_pkg::UAV_BURSTCOUNT_W-1:0]   uav_burstcount,
   input  logic [translator_bus_pkg::BYTEENABLE_W-1:0]       uav_byteenable,
   input  logic                                              uav_write,
   input  logic                                              av_beginbursttransfer,
   output logic [translator_bus_pkg::AV_ADDRESS_W-1:0]       av_address,
   output logic [translator_bus_pkg::AV_BURSTCOUNT_W-1:0]    av_burstcount,
   output logic [translator_bus_pkg::BYTEENABLE_W-1:0]       av_writebyteenable
);

   import translator_bus_pkg::*;

   logic [AV_ADDRESS_W-1:0]    word_address;
   logic [AV_BURSTCOUNT_W-1:0] word_burstcount;
   logic [AV_ADDRESS_W-1:0]    address_reg;
   logic [AV_BURSTCOUNT_W-1:0] burstcount_reg;

   // ---------------------------------------------------------------------
   // Byte to word conversion
   // ---------------------------------------------------------------------
   assign word_address = uav_address.word.index[AV_ADDRESS_W-1:0];

   // Byte count divided by the word size
   assign word_burstcount = uav_burstcount[BYTE_OFFSET_W +: AV_BURSTCOUNT_W];

   // ---------------------------------------------------------------------
   // Burst hold
   // ---------------------------------------------------------------------
   // Captured on the first beat, replayed on every later cycle of the burst
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         address_reg    <= '0;
         burstcount_reg <= '0;
      end else if (av_beginbursttransfer) begin
         address_reg    <= word_address;
         burstcount_reg <= word_burstcount;
      end
   end

   always_comb begin
      if (av_beginbursttransfer) begin
         av_address    = word_address;
         av_burstcount = word_burstcount;
      end else begin
         av_address    = address_reg;
         av_burstcount = burstcount_reg;
      end
   end

   // Lanes only enabled while a write is presented
   assign av_writebyteenable = {BYTEENABLE_W{uav_write}} & uav_byteenable;

endmodule

//--- hdl/slave_timing_pkg.sv
// Fixed timing of the one attached slave; all wait counts must stay below 2**WAIT_COUNT_W
package slave_timing_pkg;

   // ---------------------------------------------------------------------
   // Wait states of the slave, in clock cycles
   // ---------------------------------------------------------------------
   localparam int SETUP_WAIT_CYCLES = 1;
   localparam int READ_WAIT_CYCLES  = 2;
   localparam int WRITE_WAIT_CYCLES = 1;
   localparam int DATA_HOLD_CYCLES  = 1;

   // Counter values at which each phase ends
   localparam int READ_WAIT_INDEXED  = SETUP_WAIT_CYCLES + READ_WAIT_CYCLES;
   localparam int WRITE_WAIT_INDEXED = SETUP_WAIT_CYCLES + WRITE_WAIT_CYCLES;
   localparam int DATA_HOLD_INDEXED  = WRITE_WAIT_INDEXED + DATA_HOLD_CYCLES;

   // Wide enough for the larger of the two end indices
   localparam int WAIT_COUNT_W = $clog2(((READ_WAIT_INDEXED > DATA_HOLD_INDEXED) ?
                                         READ_WAIT_INDEXED : DATA_HOLD_INDEXED) + 1);

   // ---------------------------------------------------------------------
   // Read data return
   // ---------------------------------------------------------------------
   // Cycles from read acceptance to valid data, at least 1
   localparam int READ_LATENCY = 2;

endpackage

//--- hdl/translator_bus_pkg.sv
// Single fixed configuration: 32-bit byte addresses, 16-bit word addresses, 4-byte words only
package translator_bus_pkg;

   // ---------------------------------------------------------------------
   // Bus widths
   // ---------------------------------------------------------------------
   localparam int UAV_ADDRESS_W = 32;
   localparam int AV_ADDRESS_W  = 16;
   localparam int DATA_W        = 32;
   localparam int BYTEENABLE_W  = 4;

   // Byte lanes inside one word, as address bits
   localparam int BYTE_OFFSET_W = 2;
   localparam int WORD_INDEX_W  = UAV_ADDRESS_W - BYTE_OFFSET_W;

   // ---------------------------------------------------------------------
   // Burst counts
   // ---------------------------------------------------------------------
   // Master side counts bytes, slave side counts words
   localparam int UAV_BURSTCOUNT_W = 6;
   localparam int AV_BURSTCOUNT_W  = 4;

   // Remaining byte count of the last beat in a burst
   localparam int BYTES_PER_WORD = 4;

   // ---------------------------------------------------------------------
   // Universal address, seen as raw bytes or as word index plus offset
   // ---------------------------------------------------------------------
   typedef union packed {
      logic [UAV_ADDRESS_W-1:0] raw;
      struct packed {
         logic [WORD_INDEX_W-1:0]  index;
         logic [BYTE_OFFSET_W-1:0] offset;
      } word;
   } uav_address_t;

endpackage
